//--- verilog/rvga_pkg.sv
package rvga_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes.
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_branch = 7'b1100011;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  localparam logic [6:0] f7_sub = 7'b0100000;

  localparam int alu_op_w = 3;

  localparam logic [alu_op_w-1:0] alu_add = 3'd0;
  localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
  localparam logic [alu_op_w-1:0] alu_and = 3'd2;
  localparam logic [alu_op_w-1:0] alu_or = 3'd3;
  localparam logic [alu_op_w-1:0] alu_xor = 3'd4;
  localparam logic [alu_op_w-1:0] alu_slt = 3'd5;

  // One instruction word, seen as R, I or B format.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } i;
    struct packed {
      logic imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic imm_11;
      logic [6:0] opcode;
    } b;
  } rvga_instr_u;

endpackage : rvga_pkg

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import rvga_pkg::*;
  (input logic clk_i
  , input logic arst_n_i
  , input logic stall_i
  , input logic flush_i
  , input logic instr_v_i
  , input rvga_instr_u instr_i
  , input logic [xlen-1:0] pc_i
  , output logic dec_v_o
  , output logic [reg_addr_w-1:0] rs1_o
  , output logic [reg_addr_w-1:0] rs2_o
  , output logic [reg_addr_w-1:0] rd_o
  , output logic [alu_op_w-1:0] alu_op_o
  , output logic imm_v_o
  , output logic [xlen-1:0] imm_o
  , output logic br_v_o
  , output logic br_ne_o
  , output logic rd_w_v_o
  , output logic [xlen-1:0] pc_o
  );

  logic [alu_op_w-1:0] alu_op_n;
  logic imm_v_n;
  logic [xlen-1:0] imm_n;
  logic br_v_n;
  logic br_ne_n;
  logic rd_w_v_n;

  always_comb begin
    alu_op_n = alu_add;
    imm_v_n = 1'b0;
    imm_n = '0;
    br_v_n = 1'b0;
    br_ne_n = 1'b0;
    rd_w_v_n = 1'b0;
    case (instr_i.r.opcode)
      opc_op: begin
        rd_w_v_n = 1'b1;
        case (instr_i.r.funct3)
          f3_add: alu_op_n = (instr_i.r.funct7 == f7_sub) ? alu_sub : alu_add;
          f3_xor: alu_op_n = alu_xor;
          f3_or: alu_op_n = alu_or;
          f3_and: alu_op_n = alu_and;
          f3_slt: alu_op_n = alu_slt;
          default: rd_w_v_n = 1'b0;
        endcase
      end
      opc_op_imm: begin
        rd_w_v_n = 1'b1;
        imm_v_n = 1'b1;
        imm_n = {{(xlen-12){instr_i.i.imm[11]}}, instr_i.i.imm};
        case (instr_i.i.funct3)
          f3_add: alu_op_n = alu_add;
          f3_xor: alu_op_n = alu_xor;
          f3_or: alu_op_n = alu_or;
          f3_and: alu_op_n = alu_and;
          default: rd_w_v_n = 1'b0; // SLTI and shifts left out.
        endcase
      end
      opc_branch: begin
        imm_n = {{(xlen-13){instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                 instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
        br_v_n = (instr_i.b.funct3 == f3_beq) || (instr_i.b.funct3 == f3_bne);
        br_ne_n = (instr_i.b.funct3 == f3_bne);
      end
      default: ;
    endcase
    if (instr_i.r.rd == '0)
      rd_w_v_n = 1'b0; // Nothing lands in x0.
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      dec_v_o <= 1'b0;
    else if (flush_i)
      dec_v_o <= 1'b0;
    else if (!stall_i)
      dec_v_o <= instr_v_i;
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      rs1_o <= instr_i.r.rs1;
      rs2_o <= instr_i.r.rs2;
      rd_o <= instr_i.r.rd;
      alu_op_o <= alu_op_n;
      imm_v_o <= imm_v_n;
      imm_o <= imm_n;
      br_v_o <= br_v_n;
      br_ne_o <= br_ne_n;
      rd_w_v_o <= rd_w_v_n;
      pc_o <= pc_i;
    end
  end

endmodule : decode_stage

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile
  import rvga_pkg::*;
  (input logic clk_i
  , input logic arst_n_i
  , input logic [reg_addr_w-1:0] rs1_i
  , input logic [reg_addr_w-1:0] rs2_i
  , output logic [xlen-1:0] rs1_data_o
  , output logic [xlen-1:0] rs2_data_o
  , input logic wr_v_i
  , input logic [reg_addr_w-1:0] wr_rd_i
  , input logic [xlen-1:0] wr_data_i
  );

  logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];
  logic wr_en;

  assign wr_en = wr_v_i && (wr_rd_i != '0); // x0 stays zero.

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < (1 << reg_addr_w); i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_rd_i] <= wr_data_i;
    end
  end

  // Same-cycle write is visible to the reads.
  assign rs1_data_o = (wr_en && (wr_rd_i == rs1_i)) ? wr_data_i : regs[rs1_i];
  assign rs2_data_o = (wr_en && (wr_rd_i == rs2_i)) ? wr_data_i : regs[rs2_i];

endmodule : regfile

//--- verilog/rfetch_stage.sv
`timescale 1ns/1ps

module rfetch_stage
  import rvga_pkg::*;
  (input logic clk_i
  , input logic arst_n_i
  , input logic stall_i
  , input logic flush_i
  , input logic dec_v_i
  , input logic [reg_addr_w-1:0] rs1_i
  , input logic [reg_addr_w-1:0] rs2_i
  , input logic [reg_addr_w-1:0] rd_i
  , input logic [alu_op_w-1:0] alu_op_i
  , input logic imm_v_i
  , input logic [xlen-1:0] imm_i
  , input logic br_v_i
  , input logic br_ne_i
  , input logic rd_w_v_i
  , input logic [xlen-1:0] pc_i
  , input logic [xlen-1:0] rs1_data_i
  , input logic [xlen-1:0] rs2_data_i
  , output logic [reg_addr_w-1:0] rf_rs1_o
  , output logic [reg_addr_w-1:0] rf_rs2_o
  , output logic rf_v_o
  , output logic [reg_addr_w-1:0] rd_o
  , output logic [alu_op_w-1:0] alu_op_o
  , output logic imm_v_o
  , output logic [xlen-1:0] imm_o
  , output logic br_v_o
  , output logic br_ne_o
  , output logic rd_w_v_o
  , output logic [xlen-1:0] pc_o
  , output logic [xlen-1:0] op_a_o
  , output logic [xlen-1:0] op_b_o
  );

  logic [xlen-1:0] op_b_n;

  assign rf_rs1_o = rs1_i;
  assign rf_rs2_o = rs2_i;
  assign op_b_n = imm_v_i ? imm_i : rs2_data_i; // I-type takes the immediate.

  // Bubble on flush, hold on stall.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      rf_v_o <= 1'b0;
    else if (flush_i)
      rf_v_o <= 1'b0;
    else if (!stall_i)
      rf_v_o <= dec_v_i;
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      rd_o <= rd_i;
      alu_op_o <= alu_op_i;
      imm_v_o <= imm_v_i;
      imm_o <= imm_i;
      br_v_o <= br_v_i;
      br_ne_o <= br_ne_i;
      rd_w_v_o <= rd_w_v_i;
      pc_o <= pc_i;
      op_a_o <= rs1_data_i;
      op_b_o <= op_b_n;
    end
  end

endmodule : rfetch_stage

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import rvga_pkg::*;
  (input logic clk_i
  , input logic arst_n_i
  , input logic stall_i
  , input logic rf_v_i
  , input logic [reg_addr_w-1:0] rd_i
  , input logic [alu_op_w-1:0] alu_op_i
  , input logic imm_v_i
  , input logic [xlen-1:0] imm_i
  , input logic br_v_i
  , input logic br_ne_i
  , input logic rd_w_v_i
  , input logic [xlen-1:0] pc_i
  , input logic [xlen-1:0] op_a_i
  , input logic [xlen-1:0] op_b_i
  , output logic wb_v_o
  , output logic [reg_addr_w-1:0] wb_rd_o
  , output logic [xlen-1:0] wb_data_o
  , output logic br_v_o
  , output logic [xlen-1:0] br_target_o
  );

  logic [xlen-1:0] alu_res;
  logic slt_res;
  logic br_taken;

  assign slt_res = $signed(op_a_i) < $signed(op_b_i);

  always_comb begin
    case (alu_op_i)
      alu_add: alu_res = op_a_i + op_b_i;
      alu_sub: alu_res = op_a_i - op_b_i;
      alu_and: alu_res = op_a_i & op_b_i;
      alu_or: alu_res = op_a_i | op_b_i;
      alu_xor: alu_res = op_a_i ^ op_b_i;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, slt_res};
      default: alu_res = op_a_i + op_b_i;
    endcase
  end

  // Branches compare two registers, never an immediate.
  assign br_taken = rf_v_i && br_v_i && !imm_v_i && ((op_a_i == op_b_i) ^ br_ne_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_v_o <= 1'b0;
      br_v_o <= 1'b0;
    end else begin
      wb_v_o <= !stall_i && rf_v_i && rd_w_v_i; // Bubble while stalled.
      br_v_o <= !stall_i && br_taken;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o <= rd_i;
    wb_data_o <= alu_res;
    br_target_o <= pc_i + imm_i;
  end

endmodule : execute_stage

//--- verilog/rvga_core.sv
`timescale 1ns/1ps

module rvga_core
  import rvga_pkg::*;
  (input logic clk_i
  , input logic arst_n_i
  , input logic instr_v_i
  , input rvga_instr_u instr_i
  , input logic [xlen-1:0] pc_i
  , input logic stall_i
  , input logic flush_i
  , output logic wb_v_o
  , output logic [reg_addr_w-1:0] wb_rd_o
  , output logic [xlen-1:0] wb_data_o
  , output logic br_v_o
  , output logic [xlen-1:0] br_target_o
  );

  logic flush;
  logic ex_stall;

  logic dec_v, dec_imm_v, dec_br_v, dec_br_ne, dec_rd_w_v;
  logic [reg_addr_w-1:0] dec_rs1, dec_rs2, dec_rd;
  logic [alu_op_w-1:0] dec_alu_op;
  logic [xlen-1:0] dec_imm, dec_pc;

  logic [reg_addr_w-1:0] rf_rs1, rf_rs2;
  logic [xlen-1:0] rs1_data, rs2_data;

  logic rf_v, rf_imm_v, rf_br_v, rf_br_ne, rf_rd_w_v;
  logic [reg_addr_w-1:0] rf_rd;
  logic [alu_op_w-1:0] rf_alu_op;
  logic [xlen-1:0] rf_imm, rf_pc, rf_op_a, rf_op_b;

  assign flush = flush_i | br_v_o; // Taken branch kills younger slots.
  assign ex_stall = stall_i | flush; // Instruction leaving rfetch dies too.

  decode_stage dec
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall_i), .flush_i(flush)
    , .instr_v_i(instr_v_i), .instr_i(instr_i), .pc_i(pc_i)
    , .dec_v_o(dec_v), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd)
    , .alu_op_o(dec_alu_op), .imm_v_o(dec_imm_v), .imm_o(dec_imm)
    , .br_v_o(dec_br_v), .br_ne_o(dec_br_ne), .rd_w_v_o(dec_rd_w_v), .pc_o(dec_pc)
    );

  regfile rf
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
    , .rs1_i(rf_rs1), .rs2_i(rf_rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    , .wr_v_i(wb_v_o), .wr_rd_i(wb_rd_o), .wr_data_i(wb_data_o)
    );

  rfetch_stage rfetch
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall_i), .flush_i(flush)
    , .dec_v_i(dec_v), .rs1_i(dec_rs1), .rs2_i(dec_rs2), .rd_i(dec_rd)
    , .alu_op_i(dec_alu_op), .imm_v_i(dec_imm_v), .imm_i(dec_imm)
    , .br_v_i(dec_br_v), .br_ne_i(dec_br_ne), .rd_w_v_i(dec_rd_w_v), .pc_i(dec_pc)
    , .rs1_data_i(rs1_data), .rs2_data_i(rs2_data)
    , .rf_rs1_o(rf_rs1), .rf_rs2_o(rf_rs2)
    , .rf_v_o(rf_v), .rd_o(rf_rd), .alu_op_o(rf_alu_op), .imm_v_o(rf_imm_v)
    , .imm_o(rf_imm), .br_v_o(rf_br_v), .br_ne_o(rf_br_ne), .rd_w_v_o(rf_rd_w_v)
    , .pc_o(rf_pc), .op_a_o(rf_op_a), .op_b_o(rf_op_b)
    );

  execute_stage ex
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(ex_stall)
    , .rf_v_i(rf_v), .rd_i(rf_rd), .alu_op_i(rf_alu_op), .imm_v_i(rf_imm_v)
    , .imm_i(rf_imm), .br_v_i(rf_br_v), .br_ne_i(rf_br_ne), .rd_w_v_i(rf_rd_w_v)
    , .pc_i(rf_pc), .op_a_i(rf_op_a), .op_b_i(rf_op_b)
    , .wb_v_o(wb_v_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    , .br_v_o(br_v_o), .br_target_o(br_target_o)
    );

endmodule : rvga_core

//--- verification/rvga_core_sva.sv
`timescale 1ns/1ps

module rvga_core_sva
  import rvga_pkg::*;
  (input logic clk_i
  , input logic arst_n_i
  , input logic wb_v_i
  , input logic [reg_addr_w-1:0] wb_rd_i
  , input logic br_v_i
  );

  logic both_hit = 1'b0;
  logic x0_hit = 1'b0;
  logic repeat_hit = 1'b0;
  logic any_fail;

  assign any_fail = both_hit | x0_hit | repeat_hit;

  // One execute slot gives a writeback or a branch, not both.
  wb_br_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(wb_v_i && br_v_i))
    else begin
      both_hit = 1'b1;
      $error("writeback and branch pulse in the same cycle");
    end

  wb_not_x0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_v_i |-> wb_rd_i != '0)
    else begin
      x0_hit = 1'b1;
      $error("writeback to x0");
    end

  // Flush kills the slots right behind a taken branch.
  br_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    br_v_i |=> !br_v_i)
    else begin
      repeat_hit = 1'b1;
      $error("branch pulse in two cycles in a row");
    end

endmodule : rvga_core_sva

bind rvga_core rvga_core_sva core_sva
  (.clk_i(clk_i), .arst_n_i(arst_n_i), .wb_v_i(wb_v_o), .wb_rd_i(wb_rd_o)
  , .br_v_i(br_v_o)
  );

//--- verification/rvga_core_tb.sv
`timescale 1ns/1ps

module rvga_core_tb
  import rvga_pkg::*;
  ();

  logic clk;
  logic arst_n;
  logic instr_v;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] pc;
  logic stall;
  logic flush;
  logic wb_v;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0] wb_data;
  logic br_v;
  logic [xlen-1:0] br_target;

  // Input records, one per cycle.
  logic in_v_q [$];
  logic [xlen-1:0] in_instr_q [$];
  logic [xlen-1:0] in_pc_q [$];
  logic in_stall_q [$];
  logic in_flush_q [$];

  // Expected events in order. exp_br_q marks a branch.
  logic exp_br_q [$];
  logic [reg_addr_w-1:0] exp_rd_q [$];
  logic [xlen-1:0] exp_val_q [$];

  int quiet = 0;
  int cycles = 0;

  rvga_core DUT
    (.clk_i(clk), .arst_n_i(arst_n), .instr_v_i(instr_v), .instr_i(instr), .pc_i(pc)
    , .stall_i(stall), .flush_i(flush)
    , .wb_v_o(wb_v), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    , .br_v_o(br_v), .br_target_o(br_target)
    );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("ERROR t=%0t %s", $time, why);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic read_stim();
    int fd;
    int n;
    logic [7:0] tag;
    logic [8*160-1:0] rest;
    logic v;
    logic st;
    logic fl;
    logic [xlen-1:0] w;
    logic [xlen-1:0] p;
    logic [reg_addr_w-1:0] rd;
    bit inputs_closed;
    inputs_closed = 1'b0;
    fd = $fopen("verification/rvga_stim.txt", "r");
    if (fd == 0)
      abort_run("cannot open verification/rvga_stim.txt");
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1)
        break;
      case (tag)
        "#": n = $fgets(rest, fd); // Comment line.
        "E": inputs_closed = 1'b1;
        "I": begin
          n = $fscanf(fd, "%h %h %h %h %h", v, w, p, st, fl);
          if (n != 5 || inputs_closed)
            abort_run("bad input record in stimulus file");
          in_v_q.push_back(v);
          in_instr_q.push_back(w);
          in_pc_q.push_back(p);
          in_stall_q.push_back(st);
          in_flush_q.push_back(fl);
        end
        "W": begin
          n = $fscanf(fd, "%h %h", rd, w);
          if (n != 2)
            abort_run("bad writeback record in stimulus file");
          exp_br_q.push_back(1'b0);
          exp_rd_q.push_back(rd);
          exp_val_q.push_back(w);
        end
        "B": begin
          n = $fscanf(fd, "%h", w);
          if (n != 1)
            abort_run("bad branch record in stimulus file");
          exp_br_q.push_back(1'b1);
          exp_rd_q.push_back('0);
          exp_val_q.push_back(w);
        end
        default: abort_run("unknown record type in stimulus file");
      endcase
    end
    $fclose(fd);
  endtask

  task automatic compare_event();
    if (exp_br_q.size() == 0)
      abort_run("output event seen with no expected event left");
    if (exp_br_q[0]) begin
      check_value("br_v_o", xlen'(br_v), xlen'(1));
      check_value("br_target_o", br_target, exp_val_q[0]);
    end else begin
      check_value("wb_v_o", xlen'(wb_v), xlen'(1));
      check_value("wb_rd_o", xlen'(wb_rd), xlen'(exp_rd_q[0]));
      check_value("wb_data_o", wb_data, exp_val_q[0]);
    end
    void'(exp_br_q.pop_front());
    void'(exp_rd_q.pop_front());
    void'(exp_val_q.pop_front());
  endtask

  // Outputs are settled by the falling edge.
  always @(negedge clk) begin
    if (arst_n) begin
      if (wb_v || br_v) begin
        quiet = 0;
        compare_event();
      end else begin
        quiet++;
      end
    end
  end

  initial begin
    int limit;
    @(posedge arst_n);
    limit = in_v_q.size() + 20;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > limit)
        abort_run($sformatf("timeout after %0d cycles, %0d events still expected",
                            cycles, exp_br_q.size()));
    end
  end

  initial begin
    arst_n = 1'b0;
    instr_v = 1'b0;
    instr = '0;
    pc = '0;
    stall = 1'b0;
    flush = 1'b0;
    read_stim();
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    foreach (in_v_q[i]) begin
      @(posedge clk);
      #1;
      instr_v = in_v_q[i];
      instr = in_instr_q[i];
      pc = in_pc_q[i];
      stall = in_stall_q[i];
      flush = in_flush_q[i];
    end
    @(posedge clk);
    #1;
    instr_v = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    repeat (4) @(posedge clk); // Pipeline drains.
    while (quiet < 10)
      @(posedge clk);
    if (exp_br_q.size() == 0 && !DUT.core_sva.any_fail) begin
      $display(">>> PASS");
      $finish;
    end else begin
      if (exp_br_q.size() != 0)
        $display("ERROR %0d expected events never appeared", exp_br_q.size());
      else
        $display("ERROR an assertion on the core outputs failed");
      $display(">>> FAIL");
      $fatal(1, "run failed");
    end
  end

endmodule : rvga_core_tb

//--- verification/rvga_stim.txt
# I instr_v instr pc stall flush, one input record per cycle, all hex
# E ends the inputs, then W rd data or B target per expected event, in order
I 1 00500093 00001000 0 0
I 1 ffd00113 00001004 0 0
I 1 7ff00193 00001008 0 0
I 1 00208233 0000100c 0 0
I 1 401102b3 00001010 0 0
I 1 00112333 00001014 0 0
I 1 0050a3b3 00001018 0 0
I 1 0021f433 0000101c 0 0
I 1 0040e4b3 00001020 0 0
I 1 0022c533 00001024 0 0
I 1 0f017593 00001028 0 0
I 1 f000e613 0000102c 0 0
I 1 fff1c693 00001030 0 0
I 1 00908013 00001034 0 0
I 1 00100733 00001038 0 0
# Taken BEQ, the next three slots are lost
I 1 00108863 0000103c 0 0
I 1 00100793 00001040 0 0
I 1 00200813 00001044 0 0
I 1 00300893 00001048 0 0
I 1 00400913 0000104c 0 0
I 1 fe209ce3 00001050 0 0
I 1 00700993 00001054 0 0
I 1 00800a13 00001058 0 0
I 1 00900a93 0000105c 0 0
# Two branches not taken
I 1 00208463 00001060 0 0
I 1 12300993 00001064 0 0
I 1 00e09663 00001068 0 0
I 1 00198a33 0000106c 0 0
I 1 05500a93 00001070 0 0
I 1 09900b93 00001074 1 0
I 1 09900b93 00001078 1 0
I 1 09900b93 0000107c 1 0
I 1 06600b13 00001080 0 0
I 1 001a8b93 00001084 0 0
I 1 01100c13 00001088 0 0
I 1 02200c93 0000108c 0 0
I 1 03300d13 00001090 0 0
I 1 04400d93 00001094 0 1
I 1 07700e13 00001098 0 0
I 1 00000013 0000109c 0 0
I 1 01cc8eb3 000010a0 0 0
I 1 018d6f33 000010a4 0 0
I 0 00100f93 000010a8 0 0
E
W 01 00000005
W 02 fffffffd
W 03 000007ff
W 04 00000002
W 05 fffffff8
W 06 00000001
W 07 00000000
W 08 000007fd
W 09 00000007
W 0a 00000005
W 0b 000000f0
W 0c ffffff05
W 0d fffff800
W 0e 00000005
B 0000104c
W 12 00000004
B 00001048
W 13 00000123
W 14 00000128
W 15 00000055
W 16 00000066
W 17 00000056
W 18 00000011
W 1c 00000077
W 1d 00000077
W 1e 00000011

//--- rvga.f
verilog/rvga_pkg.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/rfetch_stage.sv
verilog/execute_stage.sv
verilog/rvga_core.sv
verification/rvga_core_sva.sv
verification/rvga_core_tb.sv

//--- Makefile
TOP := rvga_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rvga.f --top-module $(TOP)

obj_dir/V$(TOP): rvga.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -f rvga.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
